// File: project.f
+incdir+verif
rtl/up_pkg.sv
rtl/up_alu.sv
rtl/up_reg_bank.sv
rtl/up_addr_unit.sv
rtl/up_controller.sv
rtl/up_top.sv
verif/up_tb.sv

// File: Makefile
SIM := obj_dir/Vup_tb
SRCS := $(wildcard rtl/*.sv) verif/up_tb.sv verif/up_tb_model.svh project.f

.PHONY: run clean

run: $(SIM)
	@out=$$(./$(SIM)); echo "$$out"; echo "$$out" | grep -qF '** PASS **'

$(SIM): $(SRCS)
	verilator --binary --assert -f project.f --top-module up_tb -o Vup_tb

clean:
	rm -rf obj_dir

// File: verif/up_tb_model.svh
function automatic void expect_write(input addr_t addr, input word_t data);
	exp_addr.push_back(addr);
	exp_data.push_back(data);
endfunction

// runs the program in image at instruction level and returns how many writes come before the irq
function automatic int predict_writes(input bit irq_at_halt);
	word_t m [256];
	word_t a;
	word_t x;
	word_t y;
	word_t c;
	word_t instr;
	addr_t pc;
	addr_t sp;
	logic  ie;
	logic  irq_done;
	int    pre;
	int    steps;
	m = image;
	a = '0;
	x = m[RESET_X_ADDR];
	y = m[RESET_Y_ADDR];
	c = m[RESET_C_ADDR];
	pc = '0;
	sp = SP_INIT;
	ie = 1'b0;
	irq_done = 1'b0;
	pre = -1;
	steps = 0;
	exp_addr.delete();
	exp_data.delete();
	while (steps < 1000) begin
		steps++;
		instr = m[pc];
		if (instr[7:4] == 4'h7 && a == '0 && c == pc) begin // a branch to itself is the halt loop
			if (irq_at_halt && !irq_done && ie) begin
				irq_done = 1'b1;
				pre = exp_addr.size();
				m[sp] = pc; // return address is the halt instruction itself
				expect_write(sp, pc);
				sp--;
				pc = m[INT_VEC_ADDR];
				continue;
			end
			break;
		end
		pc++;
		case (instr[7:4])
			4'h0: a = a + x;
			4'h1: a = a - x;
			4'h2: a = a & x;
			4'h3: a = a | x;
			4'h4: a = a << 2; // shifted twice, once per write to A
			4'h5, 4'h6: begin // these only write the auxiliary registers
			end
			4'h7: if (a == '0) pc = c;
			4'h8: begin
				sp++;
				pc = m[sp];
			end
			4'h9: begin
				m[sp] = pc;
				expect_write(sp, pc);
				sp--;
			end
			4'hA: begin
				sp++;
				c = m[sp];
			end
			4'hB: begin
				m[sp] = a;
				expect_write(sp, a);
				sp--;
			end
			4'hC: c = m[c];
			4'hD: begin
				m[c] = a;
				expect_write(c, a);
			end
			4'hE: x = m[RESET_X_ADDR];
			default: ie = ~ie;
		endcase
	end
	if (pre < 0)
		pre = exp_addr.size();
	return pre;
endfunction

// File: verif/up_tb.sv
`timescale 1ns/1ps

module up_tb import up_pkg::*; ();

	localparam int RUN_BUDGET = 600;
	localparam int IRQ_DELAY = 30; // halt sequence reaches its loop about 11 cycles after its push
	localparam int SETTLE = 60;
	localparam int N_RUNS = 10;
	localparam int CYCLE_LIMIT = N_RUNS * (12 + RUN_BUDGET + IRQ_DELAY + 4 + SETTLE) + 200;

	logic  clk = 1'b0;
	logic  nRst = 1'b0;
	logic  irq = 1'b0;
	word_t mem_rdata = '0;
	addr_t mem_addr;
	word_t mem_wdata;
	logic  mem_we;
	logic  mem_ale;

	word_t mem [256];
	word_t image [256];
	logic  ale_last = 1'b0;
	addr_t ptr;
	addr_t exp_addr [$];
	word_t exp_data [$];
	int    got = 0;
	int    check_errors = 0;
	int    tests_passed = 0;
	int    tests_failed = 0;
	int    cycles = 0;
	int    seed = 32'h7593db46;
	word_t x_val;
	logic [1:0] alu_sel;

	`include "up_tb_model.svh"

	always #4 clk = ~clk;

	up_top dut0 (
		.clk       (clk),
		.nRst      (nRst),
		.irq       (irq),
		.mem_rdata (mem_rdata),
		.mem_addr  (mem_addr),
		.mem_wdata (mem_wdata),
		.mem_we    (mem_we),
		.mem_ale   (mem_ale)
	);

	// memory image is copied in while reset is held
	always @(negedge clk) begin
		if (!nRst) begin
			for (int i = 0; i < 256; i++)
				mem[i] <= image[i];
		end else if (mem_we) begin
			mem[mem_addr] <= mem_wdata;
		end
		if (ale_last)
			mem_rdata <= mem[mem_addr]; // data returns in the cycle after ale was high
		ale_last <= mem_ale;
	end

	always @(negedge clk) begin
		if (!nRst) begin
			got = 0;
		end else if (mem_we) begin
			assert (got < exp_addr.size()) else begin
				$display("unexpected memory write of %h to address %h", mem_wdata, mem_addr);
				check_errors++;
			end
			if (got < exp_addr.size()) begin
				assert (mem_addr == exp_addr[got]) else begin
					$display("FAILED mem_addr: got %h, expected %h", mem_addr, exp_addr[got]);
					check_errors++;
				end
				assert (mem_wdata == exp_data[got]) else begin
					$display("FAILED mem_wdata: got %h, expected %h", mem_wdata, exp_data[got]);
					check_errors++;
				end
			end
			got++;
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > CYCLE_LIMIT) begin
			$display("timeout: the run did not end within %0d cycles", CYCLE_LIMIT);
			$display("** FAIL **");
			$finish;
		end
	end

	task automatic clear_image();
		for (int i = 0; i < 256; i++)
			image[i] = word_t'(i) ^ 8'h3C;
		ptr = '0;
	endtask

	task automatic set_regs(input word_t x, input word_t y, input word_t c);
		image[RESET_X_ADDR] = x;
		image[RESET_Y_ADDR] = y;
		image[RESET_C_ADDR] = c;
		image[INT_VEC_ADDR] = 8'h60;
	endtask

	task automatic put_byte(input word_t b);
		image[ptr] = b;
		ptr++;
	endtask

	// push PC, pop it into C, then load C from the pop byte, which names slot A0 to AF
	task automatic put_store(input logic [3:0] slot);
		put_byte(8'h90);
		put_byte({4'hA, slot});
		put_byte(8'hC0);
		put_byte(8'hD0);
	endtask

	task automatic put_zero_a();
		repeat (4) put_byte(8'h40);
	endtask

	task automatic put_halt(input logic [3:0] slot);
		put_byte(8'h90);
		put_byte({4'hA, slot});
		put_byte(8'hC0);
		put_byte(8'h70);
		image[{4'hA, slot}] = 8'h70;
	endtask

	task automatic run_test(input string name, input bit use_irq);
		int pre;
		int errs_before;
		int n;
		logic missing;
		pre = predict_writes(use_irq);
		errs_before = check_errors;
		@(negedge clk);
		nRst = 1'b0;
		repeat (10) @(negedge clk);
		nRst = 1'b1;
		n = 0;
		while (got < pre && n < RUN_BUDGET) begin
			@(negedge clk);
			n++;
		end
		if (use_irq) begin
			repeat (IRQ_DELAY) @(negedge clk);
			irq = 1'b1;
			repeat (4) @(negedge clk);
			irq = 1'b0;
		end
		while (got < exp_addr.size() && n < RUN_BUDGET) begin
			@(negedge clk);
			n++;
		end
		repeat (SETTLE) @(negedge clk); // late extra writes still get caught
		missing = 1'b0;
		assert (got >= exp_addr.size()) else begin
			$display("%s: only %0d of %0d memory writes were seen", name, got, exp_addr.size());
			missing = 1'b1;
		end
		if (!missing && check_errors == errs_before) begin
			$display("%-14s ok (%0d writes)", name, exp_addr.size());
			tests_passed++;
		end else begin
			$display("%-14s failed", name);
			tests_failed++;
		end
	endtask

	initial begin
		clear_image();
		set_regs(word_t'($random(seed)), word_t'($random(seed)), {4'hB, 4'($random(seed))});
		put_byte(8'h00);
		put_byte(8'hD0); // store through the C loaded at reset
		put_zero_a();
		put_halt(4'hF);
		run_test("reset_regs", 1'b0);

		for (int r = 0; r < 4; r++) begin
			clear_image();
			set_regs(word_t'($random(seed)), word_t'($random(seed)), 8'hB0);
			put_byte(8'h00);
			for (int i = 0; i < 6; i++) begin
				alu_sel = 2'($random(seed));
				put_byte({2'b00, alu_sel, 4'h0});
				put_store(4'(i));
			end
			put_zero_a();
			put_halt(4'hF);
			run_test($sformatf("alu_ops_%0d", r), 1'b0);
		end

		clear_image();
		set_regs(word_t'($random(seed)), word_t'($random(seed)), 8'hB0);
		put_byte(8'h00);
		put_byte(8'h40);
		put_store(4'h0);
		put_byte(8'h50);
		put_store(4'h1);
		put_byte(8'h60);
		put_store(4'h2);
		put_byte(8'h00);
		put_store(4'h3);
		put_byte(8'h40);
		put_store(4'h4);
		put_zero_a();
		put_halt(4'hF);
		run_test("multi_step", 1'b0);

		for (int t = 0; t < 2; t++) begin
			clear_image();
			x_val = word_t'($random(seed)) | 8'h01;
			set_regs(x_val, word_t'($random(seed)), 8'hB0);
			if (t == 1)
				put_byte(8'h00); // A becomes nonzero and the branch falls through
			put_byte(8'h90);
			put_byte(8'hAE);
			put_byte(8'hC0);
			put_byte(8'h70);
			put_store(4'h3);
			put_zero_a();
			put_halt(4'hF);
			image[8'hAE] = 8'h70;
			run_test(t == 0 ? "branch_taken" : "branch_not", 1'b0);
		end

		for (int t = 0; t < 2; t++) begin
			clear_image();
			set_regs(word_t'($random(seed)), word_t'($random(seed)), 8'hB0);
			if (t == 0)
				put_byte(8'hF0);
			put_byte(8'h00);
			put_store(4'h0);
			put_zero_a();
			put_halt(4'hF);
			ptr = 8'h60; // vector routine
			put_byte(8'h00);
			put_store(4'h1);
			put_zero_a();
			put_halt(4'hD);
			run_test(t == 0 ? "irq_enabled" : "irq_disabled", 1'b1);
		end

		$display("%0d tests passed, %0d failed, %0d check errors",
			tests_passed, tests_failed, check_errors);
		if (tests_failed == 0 && check_errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

// File: rtl/up_top.sv
`timescale 1ns/1ps

module up_top import up_pkg::*; (
	input  logic  clk,
	input  logic  nRst,
	input  logic  irq,
	input  word_t mem_rdata,
	output addr_t mem_addr,
	output word_t mem_wdata,
	output logic  mem_we,
	output logic  mem_ale
);

	dp_ctrl_t ctrl;
	opcode_t  ir;
	logic     z;
	word_t    a;
	word_t    x;
	word_t    y;
	word_t    c;
	word_t    alu_res;
	word_t    rb_wdata;

	assign rb_wdata = ctrl.op[4] ? mem_rdata : alu_res; // address-unit ops load from memory
	assign mem_we = ctrl.mem_we;
	assign mem_ale = ctrl.ale;

	up_controller controller0 (
		.clk  (clk),
		.nRst (nRst),
		.irq  (irq),
		.ir   (ir),
		.z    (z),
		.ctrl (ctrl)
	);

	up_alu alu0 (
		.op  (ctrl.op),
		.a   (a),
		.x   (x),
		.y   (y),
		.c   (c),
		.res (alu_res)
	);

	up_addr_unit addr_unit0 (
		.clk       (clk),
		.nRst      (nRst),
		.ctrl      (ctrl),
		.rdata     (mem_rdata),
		.a         (a),
		.c         (c),
		.ir        (ir),
		.z         (z),
		.mem_addr  (mem_addr),
		.mem_wdata (mem_wdata)
	);

	up_reg_bank reg_bank0 (
		.clk    (clk),
		.nRst   (nRst),
		.rb_sel (ctrl.rb_sel),
		.we     (ctrl.rb_we),
		.wdata  (rb_wdata),
		.a      (a),
		.x      (x),
		.y      (y),
		.c      (c)
	);

endmodule

// File: rtl/up_controller.sv
`timescale 1ns/1ps

module up_controller import up_pkg::*; (
	input  logic     clk,
	input  logic     nRst,
	input  logic     irq,
	input  opcode_t  ir,
	input  logic     z,
	output dp_ctrl_t ctrl
);

	ctrl_state_t state;
	logic        int_en;
	logic        irq_last;
	logic        int_go;

	assign int_go = irq & ~irq_last & int_en; // rising edge while enabled

	always_comb begin
		ctrl = '{op: DP_ADD, ir_we: 1'b0, pc_we: 1'b0, rb_sel: RB_A, rb_we: 1'b0,
			sp_we: 1'b0, mem_we: 1'b0, ale: 1'b0};
		case (state)
			load_regs_0: begin
				ctrl.op = DP_RST_X;
				ctrl.ale = 1'b1;
			end
			load_regs_1: begin
				ctrl.op = DP_RST_Y; // X arrives while Y is addressed
				ctrl.ale = 1'b1;
				ctrl.rb_sel = RB_X;
				ctrl.rb_we = 1'b1;
			end
			load_regs_2: begin
				ctrl.op = DP_RST_C;
				ctrl.ale = 1'b1;
				ctrl.rb_sel = RB_Y;
				ctrl.rb_we = 1'b1;
			end
			load_regs_3: begin
				ctrl.op = DP_RST_C; // keeps bit 4 set so C takes the memory byte
				ctrl.rb_sel = RB_C;
				ctrl.rb_we = 1'b1;
			end
			fetch: begin
				ctrl.op = DP_FETCH;
				ctrl.ale = 1'b1;
			end
			decode: begin
				ctrl.op = DP_PC_INC;
				ctrl.ir_we = 1'b1;
				ctrl.pc_we = 1'b1;
			end
			execute_1: begin
				case (ir)
					4'h0, 4'h1, 4'h2, 4'h3, 4'h4: begin
						ctrl.op = {1'b0, ir}; // opcode equals the alu code here
						ctrl.rb_we = 1'b1;
					end
					4'h5: begin
						ctrl.op = DP_INC;
						ctrl.rb_sel = RB_AUX0;
						ctrl.rb_we = 1'b1;
					end
					4'h6: begin
						ctrl.op = DP_XOR;
						ctrl.rb_sel = RB_AUX1;
						ctrl.rb_we = 1'b1;
					end
					4'h7: begin
						if (z) begin
							ctrl.op = DP_BRANCH;
							ctrl.pc_we = 1'b1;
						end
					end
					4'h8, 4'hA: begin
						ctrl.op = DP_SP_ADDR; // pop pre-increments SP
						ctrl.sp_we = 1'b1;
						ctrl.ale = 1'b1;
					end
					4'h9, 4'hB: begin
						ctrl.op = DP_SP_PUSH;
						ctrl.ale = 1'b1;
					end
					4'hC, 4'hD: begin
						ctrl.op = DP_BRANCH;
						ctrl.ale = 1'b1;
					end
					4'hE: begin
						ctrl.op = DP_RST_X;
						ctrl.ale = 1'b1;
					end
					default: begin
					end
				endcase
			end
			execute_2: begin
				case (ir)
					4'h4: begin
						ctrl.op = DP_SHL;
						ctrl.rb_sel = RB_AUX0;
						ctrl.rb_we = 1'b1;
					end
					4'h5: begin
						ctrl.op = DP_INC;
						ctrl.rb_sel = RB_AUX1;
						ctrl.rb_we = 1'b1;
					end
					4'h6: begin
						ctrl.op = DP_XOR;
						ctrl.rb_sel = RB_AUX2;
						ctrl.rb_we = 1'b1;
					end
					4'h8: begin
						ctrl.op = DP_LOAD_PC;
						ctrl.pc_we = 1'b1;
					end
					4'h9, 4'hB: begin
						ctrl.op = DP_SP_DEC;
						ctrl.sp_we = 1'b1;
					end
					4'hA: begin
						ctrl.op = DP_SP_ADDR;
						ctrl.rb_sel = RB_C;
						ctrl.rb_we = 1'b1;
					end
					4'hC: begin
						ctrl.op = DP_BRANCH;
						ctrl.rb_sel = RB_C;
						ctrl.rb_we = 1'b1;
					end
					4'hD: begin
						ctrl.op = DP_STORE;
						ctrl.mem_we = 1'b1;
					end
					4'hE: begin
						ctrl.op = DP_RST_X;
						ctrl.rb_sel = RB_X;
						ctrl.rb_we = 1'b1;
					end
					default: begin
					end
				endcase
			end
			execute_3: begin
				case (ir)
					4'h4: begin
						ctrl.op = DP_SHL;
						ctrl.rb_we = 1'b1;
					end
					4'h5: begin
						ctrl.op = DP_INC;
						ctrl.rb_sel = RB_AUX0;
						ctrl.rb_we = 1'b1;
					end
					4'h6: begin
						ctrl.op = DP_XOR;
						ctrl.rb_sel = RB_AUX1;
						ctrl.rb_we = 1'b1;
					end
					4'h9: begin
						ctrl.op = DP_PUSH_PC; // write lands at the SP latched in execute_1
						ctrl.mem_we = 1'b1;
					end
					4'hB: begin
						ctrl.op = DP_STORE;
						ctrl.mem_we = 1'b1;
					end
					default: begin
					end
				endcase
			end
			int_1: begin
				ctrl.op = DP_SP_PUSH;
				ctrl.ale = 1'b1;
			end
			int_2: begin
				ctrl.op = DP_PUSH_PC;
				ctrl.mem_we = 1'b1;
			end
			int_3: begin
				ctrl.op = DP_SP_DEC;
				ctrl.sp_we = 1'b1;
			end
			int_4: begin
				ctrl.op = DP_VEC;
				ctrl.ale = 1'b1;
			end
			int_5: begin
				ctrl.op = DP_LOAD_PC;
				ctrl.pc_we = 1'b1;
			end
			default: begin
			end
		endcase
	end

	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			state <= load_regs_0;
			int_en <= 1'b0;
			irq_last <= 1'b0;
		end else begin
			if (!int_go)
				irq_last <= irq; // a seen edge is held until fetch takes it
			case (state)
				load_regs_0: state <= load_regs_1;
				load_regs_1: state <= load_regs_2;
				load_regs_2: state <= load_regs_3;
				load_regs_3: state <= fetch;
				fetch: state <= int_go ? int_1 : decode;
				decode: state <= execute_1;
				execute_1: begin
					case (ir)
						4'h0, 4'h1, 4'h2, 4'h3, 4'h7: state <= fetch;
						4'hF: begin
							state <= fetch;
							int_en <= ~int_en;
						end
						default: state <= execute_2;
					endcase
				end
				execute_2: begin
					case (ir)
						4'h4, 4'h5, 4'h6, 4'h9, 4'hB: state <= execute_3;
						default: state <= fetch;
					endcase
				end
				execute_3: state <= fetch;
				int_1: begin
					irq_last <= irq;
					state <= int_2;
				end
				int_2: state <= int_3;
				int_3: state <= int_4;
				int_4: state <= int_5;
				int_5: state <= fetch;
				default: state <= load_regs_0;
			endcase
		end
	end

endmodule

// File: rtl/up_addr_unit.sv
`timescale 1ns/1ps

module up_addr_unit import up_pkg::*; (
	input  logic     clk,
	input  logic     nRst,
	input  dp_ctrl_t ctrl,
	input  word_t    rdata,
	input  word_t    a,
	input  word_t    c,
	output opcode_t  ir,
	output logic     z,
	output addr_t    mem_addr,
	output word_t    mem_wdata
);

	addr_t pc;
	addr_t sp;
	addr_t pc_next;
	addr_t sp_next;
	addr_t addr_next;

	assign z = (a == '0);

	assign mem_wdata = (ctrl.op == DP_PUSH_PC) ? word_t'(pc) : a;

	always_comb begin
		case (ctrl.op)
			DP_SP_ADDR: sp_next = sp + 8'd1; // pop reads one above the free slot
			DP_SP_DEC: sp_next = sp - 8'd1;
			default: sp_next = sp;
		endcase
	end

	always_comb begin
		case (ctrl.op)
			DP_PC_INC: pc_next = pc + 8'd1;
			DP_BRANCH: pc_next = c;
			DP_LOAD_PC: pc_next = rdata; // return address or vector from memory
			default: pc_next = pc;
		endcase
	end

	always_comb begin
		case (ctrl.op)
			DP_RST_X: addr_next = RESET_X_ADDR;
			DP_RST_Y: addr_next = RESET_Y_ADDR;
			DP_RST_C: addr_next = RESET_C_ADDR;
			DP_VEC: addr_next = INT_VEC_ADDR;
			DP_FETCH: addr_next = pc;
			DP_BRANCH: addr_next = c;
			DP_SP_ADDR: addr_next = sp_next;
			DP_SP_PUSH: addr_next = sp;
			default: addr_next = a;
		endcase
	end

	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			pc <= '0;
			sp <= SP_INIT;
			ir <= '0;
			mem_addr <= '0;
		end else begin
			if (ctrl.ir_we)
				ir <= rdata[7:4]; // low nibble is not used by the decoder
			if (ctrl.pc_we)
				pc <= pc_next;
			if (ctrl.sp_we)
				sp <= sp_next;
			if (ctrl.ale)
				mem_addr <= addr_next;
		end
	end

endmodule

// File: rtl/up_reg_bank.sv
`timescale 1ns/1ps

module up_reg_bank import up_pkg::*; (
	input  logic    clk,
	input  logic    nRst,
	input  rb_sel_t rb_sel,
	input  logic    we,
	input  word_t   wdata,
	output word_t   a,
	output word_t   x,
	output word_t   y,
	output word_t   c
);

	word_t regs [8];

	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			regs <= '{default: '0};
		end else if (we) begin
			regs[rb_sel] <= wdata;
		end
	end

	// A also feeds the zero flag in the address unit
	assign a = regs[RB_A];
	assign x = regs[RB_X];
	assign y = regs[RB_Y];
	assign c = regs[RB_C];

endmodule

// File: rtl/up_alu.sv
`timescale 1ns/1ps

module up_alu import up_pkg::*; (
	input  dp_op_t op,
	input  word_t  a,
	input  word_t  x,
	input  word_t  y,
	input  word_t  c,
	output word_t  res
);

	always_comb begin
		case (op)
			DP_ADD: res = a + x;
			DP_SUB: res = a - x;
			DP_AND: res = a & x;
			DP_OR: res = a | x;
			DP_SHL: res = {a[6:0], 1'b0};
			DP_INC: res = a + 8'd1;
			DP_XOR: res = a ^ y;
			default: res = c; // remaining codes pass C through
		endcase
	end

endmodule

// File: rtl/up_pkg.sv
package up_pkg;

	typedef logic [7:0] word_t;
	typedef logic [7:0] addr_t;
	typedef logic [3:0] opcode_t;
	typedef logic [4:0] dp_op_t;
	typedef logic [2:0] rb_sel_t;

	typedef enum logic [3:0] {
		load_regs_0,
		load_regs_1,
		load_regs_2,
		load_regs_3,
		fetch,
		decode,
		execute_1,
		execute_2,
		execute_3,
		int_1,
		int_2,
		int_3,
		int_4,
		int_5
	} ctrl_state_t;

	typedef struct packed {
		dp_op_t  op;
		logic    ir_we;
		logic    pc_we;
		rb_sel_t rb_sel;
		logic    rb_we;
		logic    sp_we;
		logic    mem_we;
		logic    ale;
	} dp_ctrl_t;

	// bit 4 clear selects the alu, bit 4 set the address unit
	localparam dp_op_t DP_ADD     = 5'b00000;
	localparam dp_op_t DP_SUB     = 5'b00001;
	localparam dp_op_t DP_AND     = 5'b00010;
	localparam dp_op_t DP_OR      = 5'b00011;
	localparam dp_op_t DP_SHL     = 5'b00100;
	localparam dp_op_t DP_INC     = 5'b00101;
	localparam dp_op_t DP_XOR     = 5'b00110;
	localparam dp_op_t DP_RST_X   = 5'b10000;
	localparam dp_op_t DP_RST_Y   = 5'b10001;
	localparam dp_op_t DP_VEC     = 5'b10010;
	localparam dp_op_t DP_RST_C   = 5'b10011;
	localparam dp_op_t DP_FETCH   = 5'b10100;
	localparam dp_op_t DP_PC_INC  = 5'b10101;
	localparam dp_op_t DP_BRANCH  = 5'b10110; // C is both branch target and pointer
	localparam dp_op_t DP_SP_ADDR = 5'b10111;
	localparam dp_op_t DP_LOAD_PC = 5'b11000;
	localparam dp_op_t DP_SP_PUSH = 5'b11001;
	localparam dp_op_t DP_SP_DEC  = 5'b11010;
	localparam dp_op_t DP_PUSH_PC = 5'b11011;
	localparam dp_op_t DP_STORE   = 5'b11100;

	localparam rb_sel_t RB_X    = 3'd0;
	localparam rb_sel_t RB_Y    = 3'd1;
	localparam rb_sel_t RB_C    = 3'd2;
	localparam rb_sel_t RB_A    = 3'd4;
	localparam rb_sel_t RB_AUX0 = 3'd5;
	localparam rb_sel_t RB_AUX1 = 3'd6;
	localparam rb_sel_t RB_AUX2 = 3'd7;

	localparam addr_t RESET_X_ADDR = 8'hF0;
	localparam addr_t RESET_Y_ADDR = 8'hF1;
	localparam addr_t RESET_C_ADDR = 8'hF2;
	localparam addr_t INT_VEC_ADDR = 8'hF3;
	localparam addr_t SP_INIT      = 8'hEF;

endpackage
